/* ahb_pkg.sv */
//////////////////////////////////////////////////////////////////////
// AHB-Lite encodings
// Transfer type, response and transfer size codes of the slave port
//////////////////////////////////////////////////////////////////////

`default_nettype none

package ahb_pkg;

	// HTRANS transfer types
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_t;

	// HRESP, only OKAY is ever returned
	localparam logic HRESP_OKAY = 1'b0;

	// HSIZE transfer sizes
	// Low two bits travel inside the core as bus_size
	typedef enum logic [2:0] {
		SIZE_BYTE = 3'b000,
		SIZE_HALF = 3'b001,
		SIZE_WORD = 3'b010
	} hsize_t;

endpackage

`default_nettype wire

/* crc_pkg.sv */
//////////////////////////////////////////////////////////////////////
// CRC calculator definitions
// Register map, CR field encodings, reset values and width masks
//////////////////////////////////////////////////////////////////////

`default_nettype none

package crc_pkg;

	// Register offsets, from HADDR[4:2]
	typedef enum logic [2:0] {
		REG_DR   = 3'd0,
		REG_IDR  = 3'd1,
		REG_CR   = 3'd2,
		REG_INIT = 3'd4,
		REG_POL  = 3'd5
	} crc_reg_t;

	// CR bits 4:3, polynomial width
	typedef enum logic [1:0] {
		POLY_32 = 2'd0,
		POLY_16 = 2'd1,
		POLY_8  = 2'd2,
		POLY_7  = 2'd3
	} poly_size_t;

	// CR bits 6:5, input bit reversal
	typedef enum logic [1:0] {
		REV_NONE = 2'd0,
		REV_BYTE = 2'd1,
		REV_HALF = 2'd2,
		REV_WORD = 2'd3
	} rev_in_t;

	// CR bus positions
	localparam int CR_RESET_BIT = 0;
	localparam int CR_FIELD_LSB = 3;

	// Reset values
	localparam logic [4:0]  RESET_CR   = 5'h00;
	localparam logic [31:0] RESET_INIT = 32'hFFFF_FFFF;
	localparam logic [31:0] RESET_POLY = 32'h04C1_1DB7;

	// Value masks for each polynomial width
	localparam logic [31:0] MASK_32 = 32'hFFFF_FFFF;
	localparam logic [31:0] MASK_16 = 32'h0000_FFFF;
	localparam logic [31:0] MASK_8  = 32'h0000_00FF;
	localparam logic [31:0] MASK_7  = 32'h0000_007F;

	function automatic logic [31:0] poly_mask(input poly_size_t size);
		logic [31:0] mask;
		case (size)
			POLY_16: mask = MASK_16;
			POLY_8:  mask = MASK_8;
			POLY_7:  mask = MASK_7;
			default: mask = MASK_32;
		endcase
		return mask;
	endfunction

endpackage

`default_nettype wire

/* host_interface.sv */
//////////////////////////////////////////////////////////////////////
// CRC host interface
// AHB-Lite slave front end: address phase pipeline, register decode,
// control register, read data mux and wait-state generation
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module host_interface
(
	input  wire                  HCLK,
	input  wire                  HRESETn,
	// AHB-Lite slave side
	input  wire                  HSElx,
	input  wire [31:0]           HADDR,
	input  wire [1:0]            HTRANS,
	input  wire                  HWRITE,
	input  wire [2:0]            HSIZE,
	input  wire [31:0]           HWDATA,
	input  wire                  HREADY,
	output logic [31:0]          HRDATA,
	output logic                 HREADYOUT,
	output logic                 HRESP,
	// Register read back
	input  wire [31:0]           crc_out,
	input  wire [31:0]           crc_init_out,
	input  wire [31:0]           crc_poly_out,
	input  wire [7:0]            crc_idr_out,
	// Stall sources
	input  wire                  buffer_full,
	input  wire                  reset_pending,
	input  wire                  read_wait,
	// Write path and configuration
	output logic [31:0]          bus_wr,
	output logic [1:0]           bus_size,
	output crc_pkg::poly_size_t  crc_poly_size,
	output crc_pkg::rev_in_t     rev_in_type,
	output logic                 rev_out_type,
	output logic                 crc_init_en,
	output logic                 crc_idr_en,
	output logic                 crc_poly_en,
	output logic                 buffer_write_en,
	output logic                 reset_chain
);

	import ahb_pkg::*;
	import crc_pkg::*;

	// Data phase copy of the address phase
	logic        hsel_q;
	htrans_t     htrans_q;
	logic [2:0]  haddr_q;
	logic        hwrite_q;
	logic [1:0]  hsize_q;

	// CR fields {rev_out, rev_in, poly_size}
	logic [4:0]  cr_q;

	crc_reg_t    dp_reg;
	logic        sample_bus;
	logic        dp_valid;
	logic        stall;
	logic        wr_done;
	logic        cr_en;
	logic [31:0] cr_rd;

	//////////////////////////////////////////////////////////////////////
	// Address phase pipeline
	//////////////////////////////////////////////////////////////////////

	// Address phase accepted when the bus and this slave are both ready
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hsel_q   <= 1'b0;
			htrans_q <= IDLE;
		end
		else if (sample_bus)
		begin
			hsel_q   <= HSElx;
			htrans_q <= htrans_t'(HTRANS);
		end
	end

	// Register offset, direction and size of the transfer
	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_q  <= HADDR[4:2];
			hwrite_q <= HWRITE;
			hsize_q  <= HSIZE[1:0];
		end
	end

	// SEQ is accepted like NONSEQ, BUSY and IDLE are ignored
	assign dp_valid = hsel_q && (htrans_q == NONSEQ || htrans_q == SEQ);
	assign dp_reg   = crc_reg_t'(haddr_q);

	//////////////////////////////////////////////////////////////////////
	// Wait states and write strobes
	//////////////////////////////////////////////////////////////////////

	// DR write waits for a free buffer, DR read for the last byte,
	// INIT write for a pending CRC reload
	assign stall = dp_valid &&
		(( hwrite_q && dp_reg == REG_DR   && buffer_full) ||
		 (!hwrite_q && dp_reg == REG_DR   && read_wait) ||
		 ( hwrite_q && dp_reg == REG_INIT && reset_pending));

	assign HREADYOUT = !stall;
	assign HRESP     = HRESP_OKAY;

	// Strobes only on the completing cycle of a write
	assign wr_done         = dp_valid && hwrite_q && !stall;
	assign buffer_write_en = wr_done && (dp_reg == REG_DR);
	assign crc_idr_en      = wr_done && (dp_reg == REG_IDR);
	assign crc_init_en     = wr_done && (dp_reg == REG_INIT);
	assign crc_poly_en     = wr_done && (dp_reg == REG_POL);
	assign cr_en           = wr_done && (dp_reg == REG_CR);

	// Write data goes straight through in its data phase
	assign bus_wr   = HWDATA;
	assign bus_size = hsize_q;

	//////////////////////////////////////////////////////////////////////
	// Control register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			cr_q <= RESET_CR;
		else if (cr_en)
			cr_q <= HWDATA[CR_FIELD_LSB +: 5];
	end

	// Bit 0 is a command, never stored
	assign reset_chain   = cr_en && HWDATA[CR_RESET_BIT];
	assign crc_poly_size = poly_size_t'(cr_q[1:0]);
	assign rev_in_type   = rev_in_t'(cr_q[3:2]);
	assign rev_out_type  = cr_q[4];

	// Read mux
	assign cr_rd = {24'h0, cr_q, 3'b000};

	always_comb
	begin
		case (dp_reg)
			REG_DR:   HRDATA = crc_out;
			REG_IDR:  HRDATA = {24'h0, crc_idr_out};
			REG_CR:   HRDATA = cr_rd;
			REG_INIT: HRDATA = crc_init_out;
			REG_POL:  HRDATA = crc_poly_out;
			// Unmapped offsets
			default:  HRDATA = 32'h0;
		endcase
	end

endmodule

`default_nettype wire

/* crc_data_buffer.sv */
//////////////////////////////////////////////////////////////////////
// CRC data buffer
// Holds one written data word after input reversal and hands its
// used bytes to the CRC engine one per clock, MSB first
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module crc_data_buffer
(
	input  wire                   HCLK,
	input  wire                   HRESETn,
	input  wire                   buffer_write_en,
	input  wire [31:0]            bus_wr,
	input  wire [1:0]             bus_size,
	input  wire crc_pkg::rev_in_t rev_in_type,
	output logic                  buffer_full,
	output logic                  byte_valid,
	output logic [7:0]            byte_data
);

	import ahb_pkg::*;
	import crc_pkg::*;

	logic [31:0] rev_word;
	logic [31:0] aligned;
	logic [2:0]  count_next;
	logic [31:0] data_q;
	logic [2:0]  count_q;

	// Input reversal, XOR of the bit index mirrors it inside a lane
	always_comb
	begin
		for (int i = 0; i < 32; i++)
		begin
			case (rev_in_type)
				REV_BYTE: rev_word[i] = bus_wr[i ^ 7];
				REV_HALF: rev_word[i] = bus_wr[i ^ 15];
				REV_WORD: rev_word[i] = bus_wr[i ^ 31];
				default:  rev_word[i] = bus_wr[i];
			endcase
		end
	end

	// Left-align the used bytes so the top byte is always next
	always_comb
	begin
		case (hsize_t'({1'b0, bus_size}))
			SIZE_BYTE:
			begin
				aligned    = {rev_word[7:0], 24'h0};
				count_next = 3'd1;
			end
			SIZE_HALF:
			begin
				aligned    = {rev_word[15:0], 16'h0};
				count_next = 3'd2;
			end
			default:
			begin
				aligned    = rev_word;
				count_next = 3'd4;
			end
		endcase
	end

	// Bytes left to send
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			count_q <= 3'd0;
		else if (buffer_write_en)
			count_q <= count_next;
		else if (count_q != 3'd0)
			count_q <= count_q - 3'd1;
	end

	always_ff @(posedge HCLK)
	begin
		if (buffer_write_en)
			data_q <= aligned;
		else if (count_q != 3'd0)
			data_q <= data_q << 8;
	end

	assign buffer_full = (count_q != 3'd0);
	// The engine takes a byte on every cycle it is offered
	assign byte_valid  = buffer_full;
	assign byte_data   = data_q[31:24];

endmodule

`default_nettype wire

/* crc_unit.sv */
//////////////////////////////////////////////////////////////////////
// CRC unit
// INIT, POL and IDR registers, byte-serial CRC engine with
// programmable width, reload sequencing and output reversal
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module crc_unit
(
	input  wire                      HCLK,
	input  wire                      HRESETn,
	input  wire [31:0]               bus_wr,
	input  wire                      crc_init_en,
	input  wire                      crc_poly_en,
	input  wire                      crc_idr_en,
	input  wire                      reset_chain,
	input  wire crc_pkg::poly_size_t crc_poly_size,
	input  wire                      rev_out_type,
	input  wire                      buffer_full,
	input  wire                      byte_valid,
	input  wire [7:0]                byte_data,
	output logic [31:0]              crc_out,
	output logic [31:0]              crc_init_out,
	output logic [31:0]              crc_poly_out,
	output logic [7:0]               crc_idr_out,
	output logic                     reset_pending,
	output logic                     read_wait
);

	import crc_pkg::*;

	logic [31:0] init_q;
	logic [31:0] poly_q;
	logic [7:0]  idr_q;
	logic [31:0] crc_q;
	logic        pend_q;

	logic [31:0] mask;
	logic [31:0] top_bit;
	logic [31:0] init_m;
	logic [31:0] poly_m;
	logic [31:0] crc_m;
	logic [31:0] crc_rev;
	logic        load_req;
	logic        do_load;

	// Eight MSB-first shift steps for one input byte
	function automatic logic [31:0] crc_byte(
		input logic [31:0] crc,
		input logic [7:0]  data,
		input logic [31:0] msk,
		input logic [31:0] top,
		input logic [31:0] pol
	);
		logic [31:0] c;
		logic        fb;
		c = crc & msk;
		for (int k = 7; k >= 0; k--)
		begin
			fb = ((c & top) != 32'h0) ^ data[k];
			c  = (c << 1) & msk;
			if (fb)
				c = c ^ pol;
		end
		return c;
	endfunction

	// Width W mask and its bit W-1
	assign mask    = poly_mask(crc_poly_size);
	assign top_bit = mask ^ (mask >> 1);
	assign init_m  = init_q & mask;
	assign poly_m  = poly_q & mask;

	//////////////////////////////////////////////////////////////////////
	// Host registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			init_q <= RESET_INIT;
			poly_q <= RESET_POLY;
			idr_q  <= 8'h00;
		end
		else
		begin
			if (crc_init_en)
				init_q <= bus_wr;
			if (crc_poly_en)
				poly_q <= bus_wr;
			if (crc_idr_en)
				idr_q <= bus_wr[7:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Reload sequencing and CRC register
	//////////////////////////////////////////////////////////////////////

	// Reload waits until the buffer has drained the old word
	assign load_req = reset_chain || pend_q;
	assign do_load  = load_req && !buffer_full;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			pend_q <= 1'b0;
		else
			pend_q <= load_req && buffer_full;
	end

	// A write to INIT also seeds the running CRC
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_q <= RESET_INIT;
		else if (crc_init_en)
			crc_q <= bus_wr & mask;
		else if (do_load)
			crc_q <= init_m;
		else if (byte_valid)
			crc_q <= crc_byte(crc_q, byte_data, mask, top_bit, poly_m);
	end

	// During the reload cycle the seed is already visible
	assign crc_m   = (pend_q ? init_m : crc_q) & mask;
	// Reversal spans all 32 bits whatever the width
	assign crc_rev = {<<{crc_m}};
	assign crc_out = rev_out_type ? crc_rev : crc_m;

	assign crc_init_out  = init_m;
	assign crc_poly_out  = poly_m;
	assign crc_idr_out   = idr_q;
	assign reset_pending = pend_q;
	assign read_wait     = buffer_full;

endmodule

`default_nettype wire

/* crc_ip.sv */
//////////////////////////////////////////////////////////////////////
// CRC calculator top level
// AHB-Lite slave with data buffer and programmable CRC unit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module crc_ip
(
	input  wire         HCLK,
	input  wire         HRESETn,
	input  wire         HSElx,
	input  wire [31:0]  HADDR,
	input  wire [1:0]   HTRANS,
	input  wire         HWRITE,
	input  wire [2:0]   HSIZE,
	input  wire [31:0]  HWDATA,
	input  wire         HREADY,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP
);

	import crc_pkg::*;

	// Host interface to buffer and unit
	logic [31:0] bus_wr;
	logic [1:0]  bus_size;
	poly_size_t  crc_poly_size;
	rev_in_t     rev_in_type;
	logic        rev_out_type;
	logic        crc_init_en;
	logic        crc_idr_en;
	logic        crc_poly_en;
	logic        buffer_write_en;
	logic        reset_chain;

	// Back to the host interface
	logic [31:0] crc_out;
	logic [31:0] crc_init_out;
	logic [31:0] crc_poly_out;
	logic [7:0]  crc_idr_out;
	logic        buffer_full;
	logic        reset_pending;
	logic        read_wait;

	// Byte stream from buffer to unit
	logic        byte_valid;
	logic [7:0]  byte_data;

	host_interface i_host_interface
	(
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.HSElx           (HSElx),
		.HADDR           (HADDR),
		.HTRANS          (HTRANS),
		.HWRITE          (HWRITE),
		.HSIZE           (HSIZE),
		.HWDATA          (HWDATA),
		.HREADY          (HREADY),
		.HRDATA          (HRDATA),
		.HREADYOUT       (HREADYOUT),
		.HRESP           (HRESP),
		.crc_out         (crc_out),
		.crc_init_out    (crc_init_out),
		.crc_poly_out    (crc_poly_out),
		.crc_idr_out     (crc_idr_out),
		.buffer_full     (buffer_full),
		.reset_pending   (reset_pending),
		.read_wait       (read_wait),
		.bus_wr          (bus_wr),
		.bus_size        (bus_size),
		.crc_poly_size   (crc_poly_size),
		.rev_in_type     (rev_in_type),
		.rev_out_type    (rev_out_type),
		.crc_init_en     (crc_init_en),
		.crc_idr_en      (crc_idr_en),
		.crc_poly_en     (crc_poly_en),
		.buffer_write_en (buffer_write_en),
		.reset_chain     (reset_chain)
	);

	crc_data_buffer i_crc_data_buffer
	(
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.buffer_write_en (buffer_write_en),
		.bus_wr          (bus_wr),
		.bus_size        (bus_size),
		.rev_in_type     (rev_in_type),
		.buffer_full     (buffer_full),
		.byte_valid      (byte_valid),
		.byte_data       (byte_data)
	);

	crc_unit i_crc_unit
	(
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.bus_wr          (bus_wr),
		.crc_init_en     (crc_init_en),
		.crc_poly_en     (crc_poly_en),
		.crc_idr_en      (crc_idr_en),
		.reset_chain     (reset_chain),
		.crc_poly_size   (crc_poly_size),
		.rev_out_type    (rev_out_type),
		.buffer_full     (buffer_full),
		.byte_valid      (byte_valid),
		.byte_data       (byte_data),
		.crc_out         (crc_out),
		.crc_init_out    (crc_init_out),
		.crc_poly_out    (crc_poly_out),
		.crc_idr_out     (crc_idr_out),
		.reset_pending   (reset_pending),
		.read_wait       (read_wait)
	);

endmodule

`default_nettype wire

/* tb_crc_ip.sv */
//////////////////////////////////////////////////////////////////////
// CRC calculator testbench
// Directed AHB-Lite tests of the register map and the CRC engine
// against a bytewise reference model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_crc_ip;

	import ahb_pkg::*;
	import crc_pkg::*;

	// Run = POL, INIT, CR, CR with reload, data words, one DR read
	localparam int WORDS_PER_RUN = 4;
	localparam int RUN_XFERS     = 5 + WORDS_PER_RUN;
	// Registers 12, CRC-32 27, sizes 12 runs, reversal 8 runs, back-pressure 21
	localparam int NUM_XFERS     = 12 + 27 + 20 * RUN_XFERS + 21;
	localparam int WATCHDOG_CYC  = NUM_XFERS * 20;

	logic        HCLK;
	logic        HRESETn;
	logic        HSElx;
	logic [31:0] HADDR;
	logic [1:0]  HTRANS;
	logic        HWRITE;
	logic [2:0]  HSIZE;
	logic [31:0] HWDATA;
	logic        HREADY;
	logic [31:0] HRDATA;
	logic        HREADYOUT;
	logic        HRESP;

	// Xorshift state
	logic [31:0] rng;
	// Set whenever a data phase sees HREADYOUT low
	logic        saw_wait;

	// Model of the DUT configuration and running CRC
	logic [31:0] model_crc;
	poly_size_t  cfg_ps;
	rev_in_t     cfg_ri;
	logic        cfg_ro;
	logic [31:0] cfg_poly;

	crc_ip i_dut
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSElx     (HSElx),
		.HADDR     (HADDR),
		.HTRANS    (HTRANS),
		.HWRITE    (HWRITE),
		.HSIZE     (HSIZE),
		.HWDATA    (HWDATA),
		.HREADY    (HREADY),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP)
	);

	initial
	begin
		HCLK = 1'b0;
		forever #50 HCLK = ~HCLK;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Polynomial width W
	function automatic int poly_width(input poly_size_t ps);
		case (ps)
			POLY_16: return 16;
			POLY_8:  return 8;
			POLY_7:  return 7;
			default: return 32;
		endcase
	endfunction

	// Low W bits set
	function automatic logic [31:0] width_mask(input poly_size_t ps);
		int w;
		w = poly_width(ps);
		return (w == 32) ? 32'hFFFF_FFFF : ((32'h1 << w) - 32'h1);
	endfunction

	// Mirror the bits inside each lane of 8, 16 or 32 bits
	function automatic logic [31:0] reverse_input(input logic [31:0] w, input rev_in_t mode);
		int          lane;
		logic [31:0] r;
		case (mode)
			REV_BYTE: lane = 8;
			REV_HALF: lane = 16;
			REV_WORD: lane = 32;
			default:  lane = 1;
		endcase
		for (int b = 0; b < 32; b += lane)
		begin
			for (int j = 0; j < lane; j++)
				r[b + j] = w[b + lane - 1 - j];
		end
		return r;
	endfunction

	// Fold one written word with its used bytes taken top byte first
	function automatic logic [31:0] ref_crc(
		input logic [31:0] crc,
		input logic [31:0] word,
		input logic [2:0]  size,
		input poly_size_t  ps,
		input rev_in_t     mode,
		input logic [31:0] poly
	);
		logic [31:0] data;
		logic [31:0] msk;
		logic [31:0] c;
		logic [7:0]  b;
		logic        fb;
		int          w;
		int          nbytes;
		w      = poly_width(ps);
		msk    = width_mask(ps);
		data   = reverse_input(word, mode);
		nbytes = (size[1:0] == 2'd0) ? 1 : ((size[1:0] == 2'd1) ? 2 : 4);
		c      = crc & msk;
		for (int n = nbytes - 1; n >= 0; n--)
		begin
			b = data[8 * n +: 8];
			for (int k = 7; k >= 0; k--)
			begin
				fb = c[w - 1] ^ b[k];
				c  = (c << 1) & msk;
				if (fb)
					c = c ^ (poly & msk);
			end
		end
		return c;
	endfunction

	// Value seen on a DR read
	function automatic logic [31:0] ref_out(input logic [31:0] crc, input poly_size_t ps,
		input logic ro);
		logic [31:0] m;
		logic [31:0] r;
		m = crc & width_mask(ps);
		for (int i = 0; i < 32; i++)
			r[i] = m[31 - i];
		return ro ? r : m;
	endfunction

	function automatic logic [31:0] reg_addr(input crc_reg_t r);
		return {27'h0, r, 2'b00};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checks and bus tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, got);
			$display("=== FAIL ===");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	task automatic next_random(output logic [31:0] r);
		rng = xorshift32(rng);
		r   = rng;
	endtask

	// Inputs change 10 ns after the rising edge
	task automatic next_cycle;
		@(posedge HCLK);
		#10;
	endtask

	// Address phase held until the slave is ready
	task automatic address_phase(input crc_reg_t r, input logic write, input logic [2:0] size);
		HSElx  = 1'b1;
		HADDR  = reg_addr(r);
		HTRANS = NONSEQ;
		HWRITE = write;
		HSIZE  = size;
		while (!HREADYOUT)
			next_cycle();
		next_cycle();
		HSElx  = 1'b0;
		HTRANS = IDLE;
	endtask

	// Stay in the data phase while HREADYOUT is low
	task automatic wait_ready;
		while (!HREADYOUT)
		begin
			saw_wait = 1'b1;
			check_eq("HRESP", {31'h0, HRESP}, {31'h0, HRESP_OKAY});
			next_cycle();
		end
		check_eq("HRESP", {31'h0, HRESP}, {31'h0, HRESP_OKAY});
	endtask

	task automatic ahb_write(input crc_reg_t r, input logic [31:0] data, input logic [2:0] size);
		address_phase(r, 1'b1, size);
		HWDATA = data;
		wait_ready();
		next_cycle();
	endtask

	task automatic ahb_read(input crc_reg_t r, output logic [31:0] data);
		address_phase(r, 1'b0, SIZE_WORD);
		wait_ready();
		data = HRDATA;
		next_cycle();
	endtask

	// Fields are written before the reload so it sees the new width
	task automatic configure(input poly_size_t ps, input rev_in_t ri, input logic ro,
		input logic [31:0] poly, input logic [31:0] init);
		logic [31:0] cr;
		cr = {24'h0, ro, ri, ps, 3'b000};
		ahb_write(REG_POL, poly, SIZE_WORD);
		ahb_write(REG_INIT, init, SIZE_WORD);
		ahb_write(REG_CR, cr, SIZE_WORD);
		ahb_write(REG_CR, cr | 32'h1, SIZE_WORD);
		cfg_ps    = ps;
		cfg_ri    = ri;
		cfg_ro    = ro;
		cfg_poly  = poly;
		model_crc = init & width_mask(ps);
	endtask

	task automatic write_data(input logic [31:0] word, input logic [2:0] size);
		ahb_write(REG_DR, word, size);
		model_crc = ref_crc(model_crc, word, size, cfg_ps, cfg_ri, cfg_poly);
	endtask

	task automatic check_dr(input string name);
		logic [31:0] got;
		ahb_read(REG_DR, got);
		check_eq(name, got, ref_out(model_crc, cfg_ps, cfg_ro));
	endtask

	// Random POL and INIT, reload, random data, read back
	task automatic crc_run(input poly_size_t ps, input rev_in_t ri, input logic ro,
		input logic [2:0] size, input int nwords);
		logic [31:0] poly;
		logic [31:0] init;
		logic [31:0] word;
		next_random(poly);
		next_random(init);
		configure(ps, ri, ro, poly, init);
		repeat (nwords)
		begin
			next_random(word);
			write_data(word, size);
		end
		check_dr("DR");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic register_round_trip;
		logic [31:0] got;
		logic [31:0] v_cr;
		logic [31:0] v_init;
		logic [31:0] v_poly;
		logic [31:0] v_idr;
		poly_size_t  ps;
		ahb_read(REG_CR, got);
		check_eq("CR reset", got, 32'h0);
		ahb_read(REG_INIT, got);
		check_eq("INIT reset", got, 32'hFFFF_FFFF);
		ahb_read(REG_POL, got);
		check_eq("POL reset", got, 32'h04C1_1DB7);
		ahb_read(REG_IDR, got);
		check_eq("IDR reset", got, 32'h0);
		next_random(v_init);
		next_random(v_poly);
		next_random(v_idr);
		next_random(v_cr);
		ahb_write(REG_INIT, v_init, SIZE_WORD);
		ahb_write(REG_POL, v_poly, SIZE_WORD);
		ahb_write(REG_IDR, v_idr, SIZE_WORD);
		ahb_write(REG_CR, v_cr, SIZE_WORD);
		// INIT and POL read back through the new width
		ps = poly_size_t'(v_cr[4:3]);
		ahb_read(REG_CR, got);
		check_eq("CR", got, {24'h0, v_cr[7:3], 3'b000});
		ahb_read(REG_INIT, got);
		check_eq("INIT", got, v_init & width_mask(ps));
		ahb_read(REG_POL, got);
		check_eq("POL", got, v_poly & width_mask(ps));
		ahb_read(REG_IDR, got);
		check_eq("IDR", got, {24'h0, v_idr[7:0]});
	endtask

	task automatic crc32_standard;
		logic [31:0] got;
		logic [31:0] word;
		// Standard check string 123456789 sent one byte per write
		configure(POLY_32, REV_NONE, 1'b0, 32'h04C1_1DB7, 32'hFFFF_FFFF);
		for (int i = 0; i < 9; i++)
			write_data(32'h31 + i, SIZE_BYTE);
		ahb_read(REG_DR, got);
		check_eq("DR model", got, ref_out(model_crc, cfg_ps, cfg_ro));
		check_eq("DR check value", got, 32'h0376_E6E7);
		configure(POLY_32, REV_NONE, 1'b0, 32'h04C1_1DB7, 32'hFFFF_FFFF);
		repeat (8)
		begin
			next_random(word);
			write_data(word, SIZE_WORD);
		end
		check_dr("DR CRC-32");
	endtask

	task automatic sizes_and_widths;
		for (int p = 0; p < 4; p++)
		begin
			for (int s = 0; s < 3; s++)
				crc_run(poly_size_t'(p[1:0]), REV_NONE, 1'b0, {1'b0, s[1:0]}, WORDS_PER_RUN);
		end
	endtask

	// Output reversal also tried on a 16-bit result
	task automatic reversal_modes;
		for (int r = 0; r < 4; r++)
		begin
			crc_run(POLY_32, rev_in_t'(r[1:0]), 1'b0, SIZE_WORD, WORDS_PER_RUN);
			crc_run(POLY_16, rev_in_t'(r[1:0]), 1'b1, SIZE_HALF, WORDS_PER_RUN);
		end
	endtask

	task automatic back_pressure;
		logic [31:0] poly;
		logic [31:0] init;
		logic [31:0] new_init;
		logic [31:0] word;
		saw_wait = 1'b0;
		crc_run(POLY_32, REV_NONE, 1'b0, SIZE_WORD, 6);
		check_eq("HREADYOUT low seen", {31'h0, saw_wait}, 32'h1);
		next_random(poly);
		next_random(init);
		next_random(new_init);
		configure(POLY_16, REV_BYTE, 1'b1, poly, init);
		next_random(word);
		write_data(word, SIZE_WORD);
		// Reload arrives while the word is still folding in
		ahb_write(REG_CR, {24'h0, cfg_ro, cfg_ri, cfg_ps, 3'b001}, SIZE_WORD);
		saw_wait = 1'b0;
		ahb_write(REG_INIT, new_init, SIZE_WORD);
		check_eq("INIT write stalled", {31'h0, saw_wait}, 32'h1);
		// New INIT seeds the next CRC
		model_crc = new_init & width_mask(cfg_ps);
		repeat (2)
		begin
			next_random(word);
			write_data(word, SIZE_WORD);
		end
		check_dr("DR after reload");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		HRESETn   = 1'b0;
		HSElx     = 1'b0;
		HADDR     = 32'h0;
		HTRANS    = IDLE;
		HWRITE    = 1'b0;
		HSIZE     = SIZE_WORD;
		HWDATA    = 32'h0;
		HREADY    = 1'b1;
		rng       = 32'h791;
		saw_wait  = 1'b0;
		model_crc = 32'hFFFF_FFFF;
		cfg_ps    = POLY_32;
		cfg_ri    = REV_NONE;
		cfg_ro    = 1'b0;
		cfg_poly  = 32'h04C1_1DB7;
		repeat (3) @(posedge HCLK);
		#10;
		HRESETn = 1'b1;
		check_eq("HREADYOUT after reset", {31'h0, HREADYOUT}, 32'h1);
		check_eq("HRESP after reset", {31'h0, HRESP}, {31'h0, HRESP_OKAY});
		register_round_trip();
		crc32_standard();
		sizes_and_widths();
		reversal_modes();
		back_pressure();
		$display("=== PASS ===");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYC) @(posedge HCLK);
		$display("=== FAIL ===");
		$fatal(1, "Watchdog expired, the bus transfers did not finish in time");
	end

endmodule

`default_nettype wire

/* crcahb.f */
ahb_pkg.sv
crc_pkg.sv
host_interface.sv
crc_data_buffer.sv
crc_unit.sv
crc_ip.sv
tb_crc_ip.sv

/* Makefile */
# Verilator lint and simulation of the CRC calculator

VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_crc_ip
FILELIST  = crcahb.f
OBJ_DIR   = obj_dir
PASS_MSG  = === PASS ===

SOURCES = $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the pass message shows up in its output
sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
